/* rtl/funct_gen_pkg.sv */
// Shared widths, encodings and pipeline records of the function generator.
package funct_gen_pkg;

	// Samples are signed Q1.15, so one sign bit and fifteen fraction bits.
	parameter int DATA_WIDTH = 16;

	// Signed integer amplitude applied to every sample.
	parameter int INT_BITS = 4;

	// Table address width, giving 64 entries for one full period.
	parameter int LUT_ADDR = 6;

	// The whole product is kept on the output, so no saturation is needed.
	parameter int DATA_WIDTH_OUT = DATA_WIDTH + INT_BITS;

	// Controller states.
	// CONFI loads the amplitude, GEN walks the table.
	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		CONFI = 2'd1,
		GEN   = 2'd2
	} gen_state_e;

	// Waveform select.
	// The encoding matches the external two-bit select input.
	typedef enum logic [1:0] {
		SINE     = 2'd0,
		COSINE   = 2'd1,
		TRIANGLE = 2'd2,
		SQUARE   = 2'd3
	} wave_sel_e;

	// One sample request from the controller.
	// It carries its own select and amplitude so that a later configure
	// phase cannot disturb samples that are still in the pipeline.
	typedef struct packed {
		logic                         valid;
		logic [LUT_ADDR-1:0]          addr;
		wave_sel_e                    sel;
		logic signed [INT_BITS-1:0]   amp;
	} sample_req_t;

	// Table read result, aligned with the request that produced it.
	// The cosine value comes from the same table a quarter period ahead.
	typedef struct packed {
		sample_req_t                  req;
		logic signed [DATA_WIDTH-1:0] sin_val;
		logic signed [DATA_WIDTH-1:0] cos_val;
	} table_rd_t;

endpackage

/* rtl/gen_control.sv */
`timescale 1ns/1ps

module gen_control #(
	parameter int DATA_WIDTH = 16,
	parameter int INT_BITS   = 4,
	parameter int LUT_ADDR   = 6
) (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         en_low_i,
	input  logic                         enh_conf_i,
	input  logic signed [INT_BITS-1:0]   amp_i,
	input  funct_gen_pkg::wave_sel_e     sel_i,
	output funct_gen_pkg::sample_req_t   req_o
);

	// Registered controller state and its next value.
	funct_gen_pkg::gen_state_e state_q;
	funct_gen_pkg::gen_state_e state_d;

	// Table address counter.
	// It wraps naturally at the table size.
	logic [LUT_ADDR-1:0] addr_cnt_q;

	// Amplitude captured during the configure state.
	logic signed [INT_BITS-1:0] amp_q;

	// The request record is sized by the package widths.
	// The parameters handed down from the top must agree with them.
	if (DATA_WIDTH != funct_gen_pkg::DATA_WIDTH ||
		INT_BITS != funct_gen_pkg::INT_BITS ||
		LUT_ADDR != funct_gen_pkg::LUT_ADDR) begin : g_width_check
		$error("gen_control widths differ from the package widths");
	end

	// Next state.
	// A configure request wins over everything, then the stop level.
	// With neither level high the generator runs.
	always_comb begin
		if (enh_conf_i) begin
			state_d = funct_gen_pkg::CONFI;
		end else if (en_low_i) begin
			state_d = funct_gen_pkg::IDLE;
		end else begin
			state_d = funct_gen_pkg::GEN;
		end
	end

	// State register.
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			state_q <= funct_gen_pkg::IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// Address counter.
	// It steps once per issued request while generating.
	// In idle and configure it is held at zero, so every run starts at
	// the beginning of the period.
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			addr_cnt_q <= '0;
		end else if (state_q == funct_gen_pkg::GEN) begin
			addr_cnt_q <= addr_cnt_q + 1'b1;
		end else begin
			addr_cnt_q <= '0;
		end
	end

	// Amplitude register.
	// It follows the amplitude input on every configure cycle and holds
	// its value in the other states.
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			amp_q <= '0;
		end else if (state_q == funct_gen_pkg::CONFI) begin
			amp_q <= amp_i;
		end
	end

	// Request assembly.
	// One request is valid on each generate cycle. The select is taken
	// live, while the amplitude comes from the stored value.
	always_comb begin
		req_o.valid = (state_q == funct_gen_pkg::GEN);
		req_o.addr  = addr_cnt_q;
		req_o.sel   = sel_i;
		req_o.amp   = amp_q;
	end

endmodule

/* rtl/sine_rom.sv */
`timescale 1ns/1ps

module sine_rom #(
	parameter int DATA_WIDTH = 16,
	parameter int LUT_ADDR   = 6
) (
	input  logic                        clk,
	input  logic                        rst,
	input  funct_gen_pkg::sample_req_t  req_i,
	output funct_gen_pkg::table_rd_t    rd_o
);

	// Offset of a quarter period for the cosine read.
	localparam logic [LUT_ADDR-1:0] QUARTER = LUT_ADDR'((2 ** LUT_ADDR) / 4);

	// One full sine period in signed Q1.15.
	logic signed [DATA_WIDTH-1:0] rom [2 ** LUT_ADDR];

	// Second read address.
	// The sum wraps at the table size, which gives the modulo.
	logic [LUT_ADDR-1:0] cos_addr;

	// Read data and the request fields that travel with it.
	logic                         valid_q;
	logic [LUT_ADDR-1:0]          addr_q;
	funct_gen_pkg::wave_sel_e     sel_q;
	logic signed [funct_gen_pkg::INT_BITS-1:0] amp_q;
	logic signed [DATA_WIDTH-1:0] sin_q;
	logic signed [DATA_WIDTH-1:0] cos_q;

	initial begin
		$readmemh("rtl/sine_table.mem", rom);
	end

	assign cos_addr = req_i.addr + QUARTER;

	// Valid bit of the registered request.
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= req_i.valid;
		end
	end

	// Two synchronous reads per cycle, one for sine and one for cosine.
	always_ff @(posedge clk) begin
		addr_q <= req_i.addr;
		sel_q  <= req_i.sel;
		amp_q  <= req_i.amp;
		sin_q  <= rom[req_i.addr];
		cos_q  <= rom[cos_addr];
	end

	assign rd_o.req.valid = valid_q;
	assign rd_o.req.addr  = addr_q;
	assign rd_o.req.sel   = sel_q;
	assign rd_o.req.amp   = amp_q;
	assign rd_o.sin_val   = sin_q;
	assign rd_o.cos_val   = cos_q;

endmodule

/* rtl/wave_shaper.sv */
`timescale 1ns/1ps

module wave_shaper #(
	parameter int DATA_WIDTH     = 16,
	parameter int INT_BITS       = 4,
	parameter int LUT_ADDR       = 6,
	parameter int DATA_WIDTH_OUT = 20
) (
	input  logic                              clk,
	input  logic                              rst,
	input  funct_gen_pkg::table_rd_t          rd_i,
	output logic signed [DATA_WIDTH_OUT-1:0]  data_o,
	output logic                              wr_en_o
);

	// Full scale values of a Q1.15 sample.
	localparam logic signed [DATA_WIDTH-1:0] MAX_VAL = {1'b0, {(DATA_WIDTH-1){1'b1}}};
	localparam logic signed [DATA_WIDTH-1:0] MIN_VAL = {1'b1, {(DATA_WIDTH-1){1'b0}}};

	// The ramp step is the full range divided by half the table.
	localparam int RAMP_SHIFT = DATA_WIDTH - LUT_ADDR + 1;

	// Position inside the current half period.
	logic [LUT_ADDR-2:0] half_pos;

	// Second half of the period.
	logic second_half;

	// Unsigned ramp over one half period, from zero to just below full range.
	logic [DATA_WIDTH-1:0] ramp;

	// Rising edge of the triangle.
	logic signed [DATA_WIDTH-1:0] tri_rise;

	logic signed [DATA_WIDTH-1:0] tri_val;
	logic signed [DATA_WIDTH-1:0] squ_val;
	logic signed [DATA_WIDTH-1:0] sel_val;

	// Stage one registers.
	logic                         valid_q;
	logic signed [DATA_WIDTH-1:0] sample_q;
	logic signed [INT_BITS-1:0]   amp_q;

	// Signed product of the chosen sample and the amplitude.
	logic signed [DATA_WIDTH_OUT-1:0] product;

	assign half_pos    = rd_i.req.addr[LUT_ADDR-2:0];
	assign second_half = rd_i.req.addr[LUT_ADDR-1];
	assign ramp        = {half_pos, {RAMP_SHIFT{1'b0}}};

	// Adding the most negative value only flips the top bit of the ramp.
	assign tri_rise = {~ramp[DATA_WIDTH-1], ramp[DATA_WIDTH-2:0]};

	// The falling half is full scale minus the ramp.
	// In two's complement that is the bitwise inverse of the rising value.
	assign tri_val = second_half ? ~tri_rise : tri_rise;

	// Square wave, high for the first half of the period.
	assign squ_val = second_half ? MIN_VAL : MAX_VAL;

	// Waveform multiplexer.
	always_comb begin
		unique case (rd_i.req.sel)
			funct_gen_pkg::SINE:     sel_val = rd_i.sin_val;
			funct_gen_pkg::COSINE:   sel_val = rd_i.cos_val;
			funct_gen_pkg::TRIANGLE: sel_val = tri_val;
			funct_gen_pkg::SQUARE:   sel_val = squ_val;
			default:                 sel_val = '0;
		endcase
	end

	// Stage one control.
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= rd_i.req.valid;
		end
	end

	// Stage one data, kept together with the amplitude of its request.
	always_ff @(posedge clk) begin
		sample_q <= sel_val;
		amp_q    <= rd_i.req.amp;
	end

	// Both operands are signed, so they are sign extended to the output
	// width and the product fits exactly.
	assign product = sample_q * amp_q;

	// Output register.
	// The sample is loaded only with a strobe and held otherwise.
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			data_o  <= '0;
			wr_en_o <= 1'b0;
		end else begin
			wr_en_o <= valid_q;
			if (valid_q) begin
				data_o <= product;
			end
		end
	end

endmodule

/* rtl/funct_gen_top.sv */
`timescale 1ns/1ps

module funct_gen_top #(
	parameter int DATA_WIDTH     = funct_gen_pkg::DATA_WIDTH,
	parameter int INT_BITS       = funct_gen_pkg::INT_BITS,
	parameter int LUT_ADDR       = funct_gen_pkg::LUT_ADDR,
	parameter int DATA_WIDTH_OUT = funct_gen_pkg::DATA_WIDTH_OUT
) (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              en_low_i,
	input  logic                              enh_conf_i,
	input  logic signed [INT_BITS-1:0]        amp_i,
	input  logic [1:0]                        sel_i,
	output logic signed [DATA_WIDTH_OUT-1:0]  data_o,
	output logic                              wr_en_o
);

	// Waveform select in its enum form.
	funct_gen_pkg::wave_sel_e sel;

	// Request from the controller to the table.
	funct_gen_pkg::sample_req_t req;

	// Table result towards the shaper.
	funct_gen_pkg::table_rd_t rd;

	assign sel = funct_gen_pkg::wave_sel_e'(sel_i);

	gen_control #(
		.DATA_WIDTH (DATA_WIDTH),
		.INT_BITS   (INT_BITS),
		.LUT_ADDR   (LUT_ADDR)
	) u_gen_control (
		.clk        (clk),
		.rst        (rst),
		.en_low_i   (en_low_i),
		.enh_conf_i (enh_conf_i),
		.amp_i      (amp_i),
		.sel_i      (sel),
		.req_o      (req)
	);

	sine_rom #(
		.DATA_WIDTH (DATA_WIDTH),
		.LUT_ADDR   (LUT_ADDR)
	) u_sine_rom (
		.clk   (clk),
		.rst   (rst),
		.req_i (req),
		.rd_o  (rd)
	);

	wave_shaper #(
		.DATA_WIDTH     (DATA_WIDTH),
		.INT_BITS       (INT_BITS),
		.LUT_ADDR       (LUT_ADDR),
		.DATA_WIDTH_OUT (DATA_WIDTH_OUT)
	) u_wave_shaper (
		.clk     (clk),
		.rst     (rst),
		.rd_i    (rd),
		.data_o  (data_o),
		.wr_en_o (wr_en_o)
	);

endmodule

/* tests/tb_funct_gen.sv */
`timescale 1ns/1ps

module tb_funct_gen;

	// Clock period in ns.
	localparam int CLK_PERIOD = 100;

	localparam int DW    = funct_gen_pkg::DATA_WIDTH;
	localparam int IB    = funct_gen_pkg::INT_BITS;
	localparam int AW    = funct_gen_pkg::LUT_ADDR;
	localparam int OUT_W = funct_gen_pkg::DATA_WIDTH_OUT;

	// Table geometry.
	localparam int TABLE_SIZE = 2 ** AW;
	localparam int HALF       = TABLE_SIZE / 2;
	localparam int QUARTER    = TABLE_SIZE / 4;

	// Full scale of a Q1.15 sample and the triangle step per address.
	localparam int FULL_POS  = (2 ** (DW - 1)) - 1;
	localparam int FULL_NEG  = -(2 ** (DW - 1));
	localparam int RAMP_STEP = (2 ** DW) / HALF;

	// Length of each test phase in clock cycles.
	localparam int RESET_CYCLES     = 16;
	localparam int IDLE_CYCLES      = 20;
	localparam int CONF_CYCLES      = 4;
	localparam int TABLE_RUN_CYCLES = 80;
	localparam int SHAPE_RUN_CYCLES = 70;
	localparam int NUM_AMPS         = 4;
	localparam int RANDOM_CYCLES    = 400;
	localparam int DRAIN_CYCLES     = 8;
	localparam int TAIL_CYCLES      = 8;
	localparam int STIM_CYCLES      = RESET_CYCLES + IDLE_CYCLES + CONF_CYCLES +
		2 * TABLE_RUN_CYCLES + NUM_AMPS * (CONF_CYCLES + 2 * SHAPE_RUN_CYCLES) +
		RANDOM_CYCLES + DRAIN_CYCLES + TAIL_CYCLES;

	logic                    clk;
	logic                    rst;
	logic                    en_low_i;
	logic                    enh_conf_i;
	logic signed [IB-1:0]    amp_i;
	logic [1:0]              sel_i;
	logic signed [OUT_W-1:0] data_o;
	logic                    wr_en_o;

	// Seed for every random draw of the run.
	integer seed;

	// Copy of the sine table read from the same data file as the ROM.
	logic signed [DW-1:0] sine_mem [TABLE_SIZE];

	// Expected samples in issue order.
	int exp_q [$];

	// Model of the controller, advanced on each rising edge.
	funct_gen_pkg::gen_state_e m_state = funct_gen_pkg::IDLE;
	int m_addr = 0;
	int m_amp  = 0;

	// Counts of issued requests and of output strobes.
	int gen_cycles  = 0;
	int pulse_count = 0;

	// Last strobed output, which data_o must hold between strobes.
	logic signed [OUT_W-1:0] last_data = '0;

	funct_gen_top u_dut (
		.clk        (clk),
		.rst        (rst),
		.en_low_i   (en_low_i),
		.enh_conf_i (enh_conf_i),
		.amp_i      (amp_i),
		.sel_i      (sel_i),
		.data_o     (data_o),
		.wr_en_o    (wr_en_o)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) clk = ~clk;
		end
	end

	// Prints the fail message and ends the run.
	task automatic stop_with_failure();
		$display("Testbench failed");
		$fatal(1, "Simulation stopped on the first failure.");
	endtask

	// Next controller state.
	// Configure wins over the stop level.
	function automatic funct_gen_pkg::gen_state_e next_state(input logic conf,
		input logic low);
		if (conf) begin
			return funct_gen_pkg::CONFI;
		end else if (low) begin
			return funct_gen_pkg::IDLE;
		end
		return funct_gen_pkg::GEN;
	endfunction

	// Expected output for one request, from the waveform rules.
	function automatic int expected_sample(input int addr, input int sel, input int amp);
		int sample;
		case (sel)
			funct_gen_pkg::SINE: begin
				sample = sine_mem[addr];
			end
			funct_gen_pkg::COSINE: begin
				sample = sine_mem[(addr + QUARTER) % TABLE_SIZE];
			end
			funct_gen_pkg::TRIANGLE: begin
				if (addr < HALF) begin
					sample = FULL_NEG + RAMP_STEP * addr;
				end else begin
					sample = FULL_POS - RAMP_STEP * (addr - HALF);
				end
			end
			default: begin
				sample = (addr < HALF) ? FULL_POS : FULL_NEG;
			end
		endcase
		return sample * amp;
	endfunction

	// Holds the generator stopped.
	task automatic hold_idle(input int cycles);
		en_low_i   = 1'b1;
		enh_conf_i = 1'b0;
		repeat (cycles) @(negedge clk);
	endtask

	// Requests the configure state with a fixed amplitude.
	task automatic configure_amplitude(input logic signed [IB-1:0] amp, input int cycles);
		enh_conf_i = 1'b1;
		amp_i      = amp;
		repeat (cycles) @(negedge clk);
	endtask

	// Lets the generator run with one waveform.
	task automatic run_waveform(input funct_gen_pkg::wave_sel_e sel, input int cycles);
		enh_conf_i = 1'b0;
		en_low_i   = 1'b0;
		sel_i      = sel;
		repeat (cycles) @(negedge clk);
	endtask

	// Changes all inputs at random and holds each setting for one to four cycles.
	task automatic switch_inputs_randomly(input int cycles);
		int hold;
		int n;
		hold = 0;
		for (n = 0; n < cycles; n++) begin
			if (hold == 0) begin
				enh_conf_i = (($random(seed) & 32'h7) == 0);
				en_low_i   = (($random(seed) & 32'h7) == 0);
				sel_i      = $random(seed);
				amp_i      = $random(seed);
				hold       = 1 + ($random(seed) & 32'h3);
			end
			hold--;
			@(negedge clk);
		end
	endtask

	// Reference model and output checker.
	// Outputs are read at the rising edge, before the DUT registers update.
	always @(posedge clk) begin : model
		int exp_val;
		if (rst) begin
			m_state   = funct_gen_pkg::IDLE;
			m_addr    = 0;
			m_amp     = 0;
			last_data = '0;
		end else begin
			if (wr_en_o) begin
				pulse_count++;
				assert (exp_q.size() > 0) else begin
					$display("At time %0t wr_en_o pulsed while no sample was expected.", $time);
					stop_with_failure();
				end
				exp_val = exp_q.pop_front();
				assert (int'(data_o) == exp_val) else begin
					$display("ERROR time %0t: data_o expected %0d, actual %0d",
						$time, exp_val, data_o);
					stop_with_failure();
				end
				last_data = data_o;
			end else begin
				// Between strobes the output keeps the last sample.
				assert (data_o == last_data) else begin
					$display("ERROR time %0t: data_o expected %0d, actual %0d",
						$time, last_data, data_o);
					stop_with_failure();
				end
			end

			// A generate cycle issues one request with the live select.
			if (m_state == funct_gen_pkg::GEN) begin
				exp_q.push_back(expected_sample(m_addr, sel_i, m_amp));
				gen_cycles++;
				m_addr = (m_addr + 1) % TABLE_SIZE;
			end else begin
				m_addr = 0;
			end

			if (m_state == funct_gen_pkg::CONFI) begin
				m_amp = amp_i;
			end
			m_state = next_state(enh_conf_i, en_low_i);
		end
	end

	// Watchdog sized from the total stimulus length plus a margin.
	initial begin : watchdog
		#((STIM_CYCLES + 100) * CLK_PERIOD);
		$display("Timeout: the run did not finish within %0d clock cycles.",
			STIM_CYCLES + 100);
		stop_with_failure();
	end

	initial begin : stimulus
		int i;
		int wait_cycles;
		logic signed [IB-1:0] amp;

		seed       = 32'hdf54_d8e3;
		rst        = 1'b1;
		en_low_i   = 1'b1;
		enh_conf_i = 1'b0;
		amp_i      = '0;
		sel_i      = funct_gen_pkg::SINE;
		$readmemh("rtl/sine_table.mem", sine_mem);

		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;

		// Output state right after reset.
		assert (wr_en_o == 1'b0) else begin
			$display("ERROR time %0t: wr_en_o expected 0, actual %0d", $time, wr_en_o);
			stop_with_failure();
		end
		assert (data_o == '0) else begin
			$display("ERROR time %0t: data_o expected 0, actual %0d", $time, data_o);
			stop_with_failure();
		end

		// Stopped generator, where no strobe may appear.
		hold_idle(IDLE_CYCLES);

		// Sine then cosine over more than one period, so the address wraps.
		amp = IB'(($random(seed) & 32'h3) + 4);
		configure_amplitude(amp, CONF_CYCLES);
		run_waveform(funct_gen_pkg::SINE, TABLE_RUN_CYCLES);
		run_waveform(funct_gen_pkg::COSINE, TABLE_RUN_CYCLES);

		// Triangle and square with positive, extreme negative, zero and
		// random negative amplitudes.
		for (i = 0; i < NUM_AMPS; i++) begin
			case (i)
				0: amp = IB'(7);
				1: amp = IB'(-8);
				2: amp = '0;
				default: amp = IB'($random(seed)) | {1'b1, {(IB-1){1'b0}}};
			endcase
			configure_amplitude(amp, CONF_CYCLES);
			run_waveform(funct_gen_pkg::TRIANGLE, SHAPE_RUN_CYCLES);
			run_waveform(funct_gen_pkg::SQUARE, SHAPE_RUN_CYCLES);
		end

		// Random switching of every input.
		switch_inputs_randomly(RANDOM_CYCLES);

		// Stop and give the pipeline a bounded time to drain.
		// A missing sample leaves the queue filled and the counts apart.
		en_low_i    = 1'b1;
		enh_conf_i  = 1'b0;
		wait_cycles = 0;
		while (exp_q.size() != 0 && wait_cycles < DRAIN_CYCLES) begin
			@(negedge clk);
			wait_cycles++;
		end

		// No further strobe may follow once the generator is stopped.
		repeat (TAIL_CYCLES) @(negedge clk);

		assert (pulse_count == gen_cycles && exp_q.size() == 0) else begin
			$display("ERROR time %0t: wr_en_o pulse count expected %0d, actual %0d",
				$time, gen_cycles, pulse_count);
			stop_with_failure();
		end
		$display("Testbench passed");
		$finish;
	end

endmodule

/* rtl/sine_table.mem */
// One signed Q1.15 sine sample per line in hex, for table addresses 0 to 63.
0000
0C8C
18F9
2528
30FB
3C56
471C
5133
5A82
62F1
6A6D
70E2
7641
7A7C
7D89
7F61
7FFF
7F61
7D89
7A7C
7641
70E2
6A6D
62F1
5A82
5133
471C
3C56
30FB
2528
18F9
0C8C
0000
F374
E707
DAD8
CF05
C3AA
B8E4
AECD
A57E
9D0F
9593
8F1E
89BF
8584
8277
809F
8001
809F
8277
8584
89BF
8F1E
9593
9D0F
A57E
AECD
B8E4
C3AA
CF05
DAD8
E707
F374

/* files.f */
rtl/funct_gen_pkg.sv
rtl/gen_control.sv
rtl/sine_rom.sv
rtl/wave_shaper.sv
rtl/funct_gen_top.sv
tests/tb_funct_gen.sv

/* Bender.yml */
package:
  name: funct_gen

sources:
  # Design sources, package first.
  - rtl/funct_gen_pkg.sv
  - rtl/gen_control.sv
  - rtl/sine_rom.sv
  - rtl/wave_shaper.sv
  - rtl/funct_gen_top.sv

  # Testbench, only in the test target.
  - target: test
    files:
      - tests/tb_funct_gen.sv
